//--- read_reg_top.f
source/rr_pkg.sv
source/gpr_file.sv
source/operand_bypass.sv
source/load_hazard.sv
source/hilo_unit.sv
source/read_reg_top.sv
verif/read_reg_tb.sv

//--- source/gpr_file.sv
`timescale 1ns/1ps

module gpr_file import rr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  stage_wr_t wb_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output data_t     raw1_o,
    output data_t     raw2_o
);

    data_t regs [NUM_REGS];

    // r0 is never written so it keeps reading as zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen && (wb_i.waddr != '0)) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign raw1_o = regs[raddr1_i];
    assign raw2_o = regs[raddr2_i];

endmodule

//--- source/hilo_unit.sv
`timescale 1ns/1ps

module hilo_unit import rr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush_i,
    input  hilo_wr_t hilo_wr_i,
    output data_t    hi_o,
    output data_t    lo_o
);

    dword_t hilo_q;
    data_t  new_hi;
    data_t  new_lo;

    assign new_hi = hilo_wr_i.wdata[2*DATA_W-1:DATA_W];
    assign new_lo = hilo_wr_i.wdata[DATA_W-1:0];

    // halves update independently, flush drops the write
    always_ff @(posedge clk) begin
        if (!rst) begin
            hilo_q <= '0;
        end else if (!flush_i) begin
            if (hilo_wr_i.wen_hi) begin
                hilo_q[2*DATA_W-1:DATA_W] <= new_hi;
            end
            if (hilo_wr_i.wen_lo) begin
                hilo_q[DATA_W-1:0] <= new_lo;
            end
        end
    end

    // same-cycle bypass from ex
    assign hi_o = hilo_wr_i.wen_hi ? new_hi : hilo_q[2*DATA_W-1:DATA_W];
    assign lo_o = hilo_wr_i.wen_lo ? new_lo : hilo_q[DATA_W-1:0];

endmodule

//--- source/load_hazard.sv
`timescale 1ns/1ps

module load_hazard import rr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  src_req_t  src_i,
    input  stage_wr_t ex_i,
    input  stage_wr_t mem_i,
    input  logic      load_done_i,
    output stall_t    stall_o
);

    stall_t held_q;

    // load in flight targeting this source
    function automatic logic load_hit(
        input stage_wr_t stage,
        input reg_addr_t addr
    );
        return stage.is_load && stage.wen && (stage.waddr != '0) &&
               (stage.waddr == addr);
    endfunction

    function automatic logic next_flag(
        input logic      en,
        input reg_addr_t addr,
        input logic      held,
        input stage_wr_t ex,
        input stage_wr_t mem,
        input logic      done
    );
        logic flag;
        if (!en) begin
            flag = 1'b0;
        end else if (load_hit(ex, addr) || load_hit(mem, addr)) begin
            flag = 1'b1;
        end else if (done) begin
            flag = 1'b0;
        end else begin
            flag = held;
        end
        return flag;
    endfunction

    always_comb begin
        stall_o[1] = next_flag(src_i.ren1, src_i.raddr1, held_q[1], ex_i, mem_i, load_done_i);
        stall_o[0] = next_flag(src_i.ren2, src_i.raddr2, held_q[0], ex_i, mem_i, load_done_i);
    end

    // sticky copy, refreshed every cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            held_q <= '0;
        end else begin
            held_q <= stall_o;
        end
    end

endmodule

//--- source/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import rr_pkg::*; (
    input  src_req_t  src_i,
    input  data_t     imm_i,
    input  logic      is_store_i,
    input  stage_wr_t ex_i,
    input  stage_wr_t mem_i,
    input  stage_wr_t wb_i,
    input  data_t     raw1_i,
    input  data_t     raw2_i,
    output data_t     rdata1_o,
    output data_t     rdata2_o,
    output data_t     store_data_o
);

    // stage hit: write enabled, not r0, same index
    function automatic logic stage_hit(
        input stage_wr_t stage,
        input reg_addr_t addr
    );
        return stage.wen && (stage.waddr != '0) && (stage.waddr == addr);
    endfunction

    // priority ex > mem > wb > register file
    function automatic data_t forward(
        input reg_addr_t addr,
        input data_t     raw,
        input stage_wr_t ex,
        input stage_wr_t mem,
        input stage_wr_t wb
    );
        data_t value;
        if (stage_hit(ex, addr)) begin
            value = ex.wdata;
        end else if (stage_hit(mem, addr)) begin
            value = mem.wdata;
        end else if (stage_hit(wb, addr)) begin
            value = wb.wdata;
        end else begin
            value = raw;
        end
        return value;
    endfunction

    data_t fwd1;
    data_t fwd2;
    logic  use_imm;

    always_comb begin
        fwd1 = forward(src_i.raddr1, raw1_i, ex_i, mem_i, wb_i);
        fwd2 = forward(src_i.raddr2, raw2_i, ex_i, mem_i, wb_i);
    end

    // stores and unread rt both take the immediate
    assign use_imm = is_store_i || !src_i.ren2;

    always_comb begin
        if (src_i.ren1) begin
            rdata1_o = fwd1;
        end else begin
            rdata1_o = '0;
        end

        if (use_imm) begin
            rdata2_o = imm_i;
        end else begin
            rdata2_o = fwd2;
        end

        // store data always comes from raddr2
        if (is_store_i) begin
            store_data_o = fwd2;
        end else begin
            store_data_o = '0;
        end
    end

endmodule

//--- source/read_reg_top.sv
`timescale 1ns/1ps

module read_reg_top import rr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_i,
    input  logic      load_done_i,

    // from decode
    input  src_req_t  src_i,
    input  data_t     imm_i,
    input  logic      is_store_i,

    // later stages
    input  stage_wr_t ex_i,
    input  stage_wr_t mem_i,
    input  stage_wr_t wb_i,
    input  hilo_wr_t  hilo_wr_i,

    // to execute
    output data_t     rdata1_o,
    output data_t     rdata2_o,
    output data_t     store_data_o,
    output data_t     hi_o,
    output data_t     lo_o,
    output stall_t    stall_o
);

    data_t raw1;
    data_t raw2;

    gpr_file gpr_file_i (
        .clk      (clk),
        .rst      (rst),
        .wb_i     (wb_i),
        .raddr1_i (src_i.raddr1),
        .raddr2_i (src_i.raddr2),
        .raw1_o   (raw1),
        .raw2_o   (raw2)
    );

    operand_bypass operand_bypass_i (
        .src_i        (src_i),
        .imm_i        (imm_i),
        .is_store_i   (is_store_i),
        .ex_i         (ex_i),
        .mem_i        (mem_i),
        .wb_i         (wb_i),
        .raw1_i       (raw1),
        .raw2_i       (raw2),
        .rdata1_o     (rdata1_o),
        .rdata2_o     (rdata2_o),
        .store_data_o (store_data_o)
    );

    // load-use detection only looks at ex and mem
    load_hazard load_hazard_i (
        .clk         (clk),
        .rst         (rst),
        .src_i       (src_i),
        .ex_i        (ex_i),
        .mem_i       (mem_i),
        .load_done_i (load_done_i),
        .stall_o     (stall_o)
    );

    hilo_unit hilo_unit_i (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (flush_i),
        .hilo_wr_i (hilo_wr_i),
        .hi_o      (hi_o),
        .lo_o      (lo_o)
    );

endmodule

//--- source/rr_pkg.sv
package rr_pkg;

    // datapath widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // hi in the upper half
    typedef logic [2*DATA_W-1:0]   dword_t;

    // result on its way down the pipe (ex, mem, wb)
    // is_load unused on the wb bus
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        data_t     wdata;
        logic      is_load;
    } stage_wr_t;

    // source request from decode
    typedef struct packed {
        logic      ren1;
        reg_addr_t raddr1;
        logic      ren2;
        reg_addr_t raddr2;
    } src_req_t;

    // ex write to hi/lo
    typedef struct packed {
        logic   wen_hi;
        logic   wen_lo;
        dword_t wdata;
    } hilo_wr_t;

    // bit 1 source 1, bit 0 source 2
    typedef logic [1:0] stall_t;

endpackage

//--- verif/read_reg_tb.sv
`timescale 1ns/1ps

module read_reg_tb import rr_pkg::*; ();

    localparam int NUM_VEC      = 33;
    localparam int NUM_COLS     = 20;
    localparam int NUM_WORDS    = NUM_VEC * NUM_COLS;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_CYCLES   = 2 * (NUM_VEC + RESET_CYCLES);

    // one cycle of stimulus plus the expected outputs
    typedef struct packed {
        logic [3:0] test;
        logic       flush;
        logic       load_done;
        logic       is_store;
        src_req_t   src;
        data_t      imm;
        stage_wr_t  ex;
        stage_wr_t  mem;
        stage_wr_t  wb;
        hilo_wr_t   hilo_wr;
        data_t      exp_rdata1;
        data_t      exp_rdata2;
        data_t      exp_store;
        data_t      exp_hi;
        data_t      exp_lo;
        stall_t     exp_stall;
    } vec_t;

    logic      clk;
    logic      rst;
    logic      flush_i;
    logic      load_done_i;
    src_req_t  src_i;
    data_t     imm_i;
    logic      is_store_i;
    stage_wr_t ex_i;
    stage_wr_t mem_i;
    stage_wr_t wb_i;
    hilo_wr_t  hilo_wr_i;
    data_t     rdata1_o;
    data_t     rdata2_o;
    data_t     store_data_o;
    data_t     hi_o;
    data_t     lo_o;
    stall_t    stall_o;

    logic [31:0] words [NUM_WORDS];
    vec_t        vecs [NUM_VEC];
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycles;

    read_reg_top read_reg_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // flags column: bit 7 wen, bit 6 load, bits 4:0 target
    function automatic stage_wr_t decode_stage(input logic [31:0] flags, input logic [31:0] data);
        stage_wr_t s;
        s.wen     = flags[7];
        s.is_load = flags[6];
        s.waddr   = flags[4:0];
        s.wdata   = data;
        return s;
    endfunction

    function automatic vec_t decode_vector(input int base);
        vec_t v;
        v.test           = words[base][3:0];
        v.flush          = words[base+1][2];
        v.load_done      = words[base+1][1];
        v.is_store       = words[base+1][0];
        v.src.ren1       = words[base+2][7];
        v.src.raddr1     = words[base+2][4:0];
        v.src.ren2       = words[base+3][7];
        v.src.raddr2     = words[base+3][4:0];
        v.imm            = words[base+4];
        v.ex             = decode_stage(words[base+5], words[base+6]);
        v.mem            = decode_stage(words[base+7], words[base+8]);
        v.wb             = decode_stage(words[base+9], words[base+10]);
        v.hilo_wr.wen_hi = words[base+11][1];
        v.hilo_wr.wen_lo = words[base+11][0];
        v.hilo_wr.wdata  = {words[base+12], words[base+13]};
        v.exp_rdata1     = words[base+14];
        v.exp_rdata2     = words[base+15];
        v.exp_store      = words[base+16];
        v.exp_hi         = words[base+17];
        v.exp_lo         = words[base+18];
        v.exp_stall      = words[base+19][1:0];
        return v;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "register file";
            2: return "forwarding priority";
            3: return "operand 2 and store data";
            4: return "load-use stall";
            5: return "hi/lo";
            6: return "reset";
            default: return "unknown";
        endcase
    endfunction

    task automatic apply_vector(input vec_t v);
        flush_i     = v.flush;
        load_done_i = v.load_done;
        is_store_i  = v.is_store;
        src_i       = v.src;
        imm_i       = v.imm;
        ex_i        = v.ex;
        mem_i       = v.mem;
        wb_i        = v.wb;
        hilo_wr_i   = v.hilo_wr;
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_stall(input stall_t exp, input stall_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: stall_o expected %b, got %b", $time, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_outputs(input vec_t v);
        check_data("rdata1_o", v.exp_rdata1, rdata1_o);
        check_data("rdata2_o", v.exp_rdata2, rdata2_o);
        check_data("store_data_o", v.exp_store, store_data_o);
        check_data("hi_o", v.exp_hi, hi_o);
        check_data("lo_o", v.exp_lo, lo_o);
        check_stall(v.exp_stall, stall_o);
    endtask

    task automatic report_test(input int id);
        if (test_errors == 0) begin
            $display("test %0d (%s): passed", id, test_name(id));
            tests_passed++;
        end else begin
            $display("test %0d (%s): failed with %0d mismatches", id, test_name(id), test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int prev_test;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst          = 1'b0;
        flush_i      = 1'b0;
        load_done_i  = 1'b0;
        is_store_i   = 1'b0;
        src_i        = '0;
        imm_i        = '0;
        ex_i         = '0;
        mem_i        = '0;
        wb_i         = '0;
        hilo_wr_i    = '0;

        $readmemh("verif/read_reg_vectors.txt", words);
        if ($isunknown(words[NUM_WORDS-1])) begin
            $display("vector file could not be read or holds too few entries");
            errors++;
        end
        for (int v = 0; v < NUM_VEC; v++) begin
            vecs[v] = decode_vector(v * NUM_COLS);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        prev_test = vecs[0].test;
        for (int v = 0; v < NUM_VEC; v++) begin
            if (vecs[v].test != prev_test) begin
                report_test(prev_test);
                prev_test = vecs[v].test;
            end
            @(posedge clk);
            #1;
            apply_vector(vecs[v]);
            // sample just ahead of the next edge
            #2;
            check_outputs(vecs[v]);
        end
        report_test(prev_test);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- verif/read_reg_vectors.txt
// test ctrl(flush,load_done,store) src1 src2 imm ex_flags ex_data mem_flags mem_data wb_flags
// wb_data hilo_en hi lo | exp: rdata1 rdata2 store_data hi lo stall  (flags: wen,load,-,addr)
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 0 85 87 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 85 1234abcd 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 87 beef 0 0 0 0 0 0 0 0 0
1 0 80 0 0 0 0 0 0 80 deadbeef 0 0 0 0 0 0 0 0 0
1 0 85 87 0 0 0 0 0 0 0 0 0 0 1234abcd beef 0 0 0 0
1 0 80 85 0 0 0 0 0 0 0 0 0 0 0 1234abcd 0 0 0 0
2 0 0 0 0 0 0 0 0 89 99 0 0 0 0 0 0 0 0 0
2 0 89 89 5 89 e1e1e1e1 89 2222 89 3333 0 0 0 e1e1e1e1 e1e1e1e1 0 0 0 0
2 0 89 89 5 0 0 89 2222 89 3333 0 0 0 2222 2222 0 0 0 0
2 0 89 89 5 0 0 0 0 89 4444 0 0 0 4444 4444 0 0 0 0
2 0 89 89 5 0 0 0 0 0 0 0 0 0 4444 4444 0 0 0 0
2 0 89 80 5 09 aaaa 80 bbbb 80 cccc 0 0 0 4444 0 0 0 0 0
3 1 85 87 10 87 7777 0 0 0 0 0 0 0 1234abcd 10 7777 0 0 0
3 1 0 89 20 0 0 0 0 0 0 0 0 0 0 20 4444 0 0 0
3 0 85 07 30 0 0 0 0 0 0 0 0 0 1234abcd 30 0 0 0 0
3 0 0 87 40 87 7777 0 0 0 0 0 0 0 0 7777 0 0 0 0
4 0 85 0 0 c5 55 0 0 0 0 0 0 0 55 0 0 0 0 2
4 0 85 0 0 0 0 0 0 0 0 0 0 0 1234abcd 0 0 0 0 2
4 0 85 0 0 0 0 0 0 0 0 0 0 0 1234abcd 0 0 0 0 2
4 2 85 0 0 0 0 0 0 0 0 0 0 0 1234abcd 0 0 0 0 0
4 0 85 0 0 0 0 0 0 0 0 0 0 0 1234abcd 0 0 0 0 0
4 0 0 87 0 0 0 c7 66 0 0 0 0 0 0 66 0 0 0 1
4 0 0 87 0 0 0 0 0 0 0 0 0 0 0 beef 0 0 0 1
4 2 0 87 0 0 0 0 0 0 0 0 0 0 0 beef 0 0 0 0
4 0 05 07 0 c5 55 c7 66 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 2 11112222 33334444 0 0 0 11112222 0 0
5 0 0 0 0 0 0 0 0 0 0 1 aaaa 5555 0 0 0 11112222 5555 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 5555 0
5 4 0 0 0 0 0 0 0 0 0 3 6 7 0 0 0 6 7 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 5555 0
5 0 0 0 0 0 0 0 0 0 0 3 8 9 0 0 0 8 9 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 9 0
